/* include/hist_defs.svh */
`ifndef HIST_DEFS_SVH
`define HIST_DEFS_SVH

// lane and pixel geometry
`define HIST_LANES        4
`define HIST_PIX_PER_LANE 2
`define HIST_PIX_W        3

// histogram shape per pixel
`define HIST_BINS  16
`define HIST_BIN_W 4
`define HIST_CNT_W 16

// tdc word layout
`define TDC_W     12
`define TDC_WIN_W 8

// frame_end pulses per bank swap
`define HIST_ACQ_NUM 3

// wishbone word address map
`define WB_ADDR_W    8
`define WB_CTRL_ADDR 8'h00
`define WB_STAT_ADDR 8'h01
// lane * 32 + pix * 16 + bin above this base
`define WB_HIST_BASE 8'h40

`endif

/* design/hist_pkg.sv */
`default_nettype none

`include "hist_defs.svh"

package hist_pkg;

    // coarse view, bin in the msbs
    typedef struct packed {
        logic [`HIST_BIN_W-1:0]        coarse_bin;
        logic [`TDC_W-`HIST_BIN_W-1:0] residue;
    } tdc_coarse_s;

    // fine view, window tag on top and bin in the lsbs
    typedef struct packed {
        logic [`TDC_WIN_W-1:0]  win_tag;
        logic [`HIST_BIN_W-1:0] fine_bin;
    } tdc_fine_s;

    // same 12 bits, two decodes
    typedef union packed {
        tdc_coarse_s coarse;
        tdc_fine_s   fine;
    } tdc_word_u;

    typedef struct packed {
        logic                   valid;
        logic [`HIST_PIX_W-1:0] pixel;
        tdc_word_u              word;
    } tdc_event_s;

    // one hit towards a lane
    typedef struct packed {
        logic                   hit;
        logic                   pix_sel;
        logic [`HIST_BIN_W-1:0] bin;
    } lane_req_s;

    typedef enum logic {
        MODE_COARSE = 1'b0,
        MODE_FINE   = 1'b1
    } hist_mode_e;

    // mode lands in bit 8 of the control word
    typedef struct packed {
        hist_mode_e            mode;
        logic [`TDC_WIN_W-1:0] window;
    } hist_cfg_s;

    typedef struct packed {
        logic                  cyc;
        logic                  stb;
        logic                  we;
        logic [`WB_ADDR_W-1:0] adr;
        logic [31:0]           dat;
    } wb_m2s_s;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_s2m_s;

endpackage

`default_nettype wire

/* design/tdc_event_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module tdc_event_router (
    input  wire                       clk,
    input  wire                       res,
    input  wire hist_pkg::tdc_event_s evt,
    input  wire                       frame_end,
    input  wire hist_pkg::hist_cfg_s  cfg,
    output hist_pkg::lane_req_s       lane_req [`HIST_LANES],
    output logic                      lane_frame_end
);
    import hist_pkg::*;

    localparam int LANE_W = $clog2(`HIST_LANES);

    logic                   keep;
    logic [LANE_W-1:0]      lane_sel;
    logic                   pix_sel;
    logic [`HIST_BIN_W-1:0] bin;
    logic [`HIST_LANES-1:0] hit_q;
    logic                   pix_sel_q;
    logic [`HIST_BIN_W-1:0] bin_q;

    // decode the tdc word by mode
    always_comb begin
        if (cfg.mode == MODE_FINE) begin
            bin  = evt.word.fine.fine_bin;
            // outside the window, dropped
            keep = evt.valid && (evt.word.fine.win_tag == cfg.window);
        end else begin
            bin  = evt.word.coarse.coarse_bin;
            keep = evt.valid;
        end
    end

    // pixel split into lane and pixel inside lane
    assign lane_sel = LANE_W'(evt.pixel / `HIST_PIX_PER_LANE);
    assign pix_sel  = 1'(evt.pixel % `HIST_PIX_PER_LANE);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            hit_q          <= '0;
            lane_frame_end <= 1'b0;
        end else begin
            // at most one lane flagged per cycle
            hit_q           <= '0;
            hit_q[lane_sel] <= keep;
            // same delay as the events so frame order holds
            lane_frame_end  <= frame_end;
        end
    end

    // shared payload, only the flagged lane uses it
    always_ff @(posedge clk) begin
        pix_sel_q <= pix_sel;
        bin_q     <= bin;
    end

    always_comb begin
        for (int i = 0; i < `HIST_LANES; i++) begin
            lane_req[i].hit     = hit_q[i];
            lane_req[i].pix_sel = pix_sel_q;
            lane_req[i].bin     = bin_q;
        end
    end

endmodule

`default_nettype wire

/* design/hist_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module hist_lane (
    input  wire                      clk,
    input  wire                      res,
    input  wire hist_pkg::lane_req_s req,
    input  wire                      frame_end,
    input  wire                      rd_en,
    input  wire                      rd_pix,
    input  wire [`HIST_BIN_W-1:0]    rd_bin,
    output logic [`HIST_CNT_W-1:0]   rd_data,
    output logic                     swap
);

    localparam int BANK_DEPTH = `HIST_PIX_PER_LANE * `HIST_BINS;
    localparam int ADDR_W     = $clog2(BANK_DEPTH);
    localparam int ACQ_W      = $clog2(`HIST_ACQ_NUM + 1);

    // two banks back to back, msb of the index picks the bank
    logic [`HIST_CNT_W-1:0] mem [2 * BANK_DEPTH];

    // active bank, the other one is drained by the readout
    logic                   bank_q;
    logic [ACQ_W-1:0]       acq_cnt_q;
    logic [ADDR_W-1:0]      req_addr;
    logic [ADDR_W-1:0]      rd_addr;
    logic [`HIST_CNT_W-1:0] rd_base;
    logic [`HIST_CNT_W-1:0] add_base;
    logic                   s1_vld_q;
    logic [ADDR_W-1:0]      s1_addr_q;
    logic [`HIST_CNT_W-1:0] s1_cnt_q;
    logic                   s2_vld_q;
    logic [ADDR_W-1:0]      s2_addr_q;
    logic [`HIST_CNT_W-1:0] s2_cnt_q;

    assign req_addr = {req.pix_sel, req.bin};
    assign rd_addr  = {rd_pix, rd_bin};

    // read stage
    // s2 writes on this same edge, so take its value instead of the bank
    assign rd_base = (s2_vld_q && s2_addr_q == req_addr) ? s2_cnt_q
                                                         : mem[{bank_q, req_addr}];

    // add stage
    // newer hit still in s2 beats the value read one cycle ago
    assign add_base = (s2_vld_q && s2_addr_q == s1_addr_q) ? s2_cnt_q : s1_cnt_q;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < 2 * BANK_DEPTH; i++) begin
                mem[i] <= '0;
            end
            bank_q    <= 1'b0;
            acq_cnt_q <= '0;
            swap      <= 1'b0;
            s1_vld_q  <= 1'b0;
            s2_vld_q  <= 1'b0;
        end else begin
            s1_vld_q <= req.hit;
            s2_vld_q <= s1_vld_q;
            // write stage, active bank only
            if (s2_vld_q) begin
                mem[{bank_q, s2_addr_q}] <= s2_cnt_q;
            end
            // read-clear hits the idle bank, never the same word as above
            if (rd_en) begin
                mem[{~bank_q, rd_addr}] <= '0;
            end
            // acquisitions per histogram
            // last events have left the pipe by the time frame_end shows up
            swap <= 1'b0;
            if (frame_end) begin
                if (acq_cnt_q == ACQ_W'(`HIST_ACQ_NUM - 1)) begin
                    acq_cnt_q <= '0;
                    bank_q    <= ~bank_q;
                    swap      <= 1'b1;
                end else begin
                    acq_cnt_q <= acq_cnt_q + 1'b1;
                end
            end
        end
    end

    // pipeline payload and readout data
    always_ff @(posedge clk) begin
        s1_addr_q <= req_addr;
        s1_cnt_q  <= rd_base;
        s2_addr_q <= s1_addr_q;
        // counts wrap at 16 bits
        s2_cnt_q  <= add_base + 1'b1;
        // old value out, zero written back on the same edge
        if (rd_en) begin
            rd_data <= mem[{~bank_q, rd_addr}];
        end
    end

endmodule

`default_nettype wire

/* design/hist_wb_readout.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module hist_wb_readout (
    input  wire                      clk,
    input  wire                      res,
    input  wire hist_pkg::wb_m2s_s   wb_i,
    output hist_pkg::wb_s2m_s        wb_o,
    output hist_pkg::hist_cfg_s      cfg,
    input  wire                      swap,
    output logic                     rd_en,
    output logic                     rd_pix,
    output logic [`HIST_BIN_W-1:0]   rd_bin,
    input  wire [`HIST_CNT_W-1:0]    rd_data [`HIST_LANES]
);
    import hist_pkg::*;

    localparam int LANE_W    = $clog2(`HIST_LANES);
    localparam int LANE_SPAN = `HIST_PIX_PER_LANE * `HIST_BINS;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_BUSY = 1'b1
    } state_e;

    state_e                 state_q;
    logic                   ack_q;
    logic [`HIST_CNT_W-1:0] swap_cnt_q;
    logic [`WB_ADDR_W-1:0]  hist_off;
    logic                   is_hist;
    logic [LANE_W-1:0]      off_lane;
    logic                   off_pix;
    logic [`HIST_BIN_W-1:0] off_bin;

    // histogram window decode
    assign hist_off = wb_i.adr - `WB_HIST_BASE;
    assign is_hist  = (wb_i.adr >= `WB_HIST_BASE) &&
                      (hist_off < `WB_ADDR_W'(`HIST_LANES * LANE_SPAN));
    assign off_lane = LANE_W'(hist_off / LANE_SPAN);
    // lsb of offset / 16 is the pixel inside the lane
    assign off_pix  = 1'(hist_off / `HIST_BINS);
    assign off_bin  = `HIST_BIN_W'(hist_off);

    // idle sees the request, busy raises ack and then drops it
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state_q    <= ST_IDLE;
            ack_q      <= 1'b0;
            rd_en      <= 1'b0;
            cfg        <= '{mode: MODE_COARSE, window: '0};
            swap_cnt_q <= '0;
        end else begin
            rd_en <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (wb_i.cyc && wb_i.stb) begin
                        state_q <= ST_BUSY;
                        // lane memory read in the first busy cycle
                        rd_en   <= is_hist && !wb_i.we;
                    end
                end
                ST_BUSY: begin
                    ack_q <= !ack_q;
                    if (ack_q) begin
                        state_q <= ST_IDLE;
                    end else if (wb_i.we && wb_i.adr == `WB_CTRL_ADDR) begin
                        cfg.mode   <= hist_mode_e'(wb_i.dat[8]);
                        cfg.window <= wb_i.dat[7:0];
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
            // completed histograms, lane 0 stands for all
            if (swap) begin
                swap_cnt_q <= swap_cnt_q + 1'b1;
            end
        end
    end

    // address held by the master, so just register the decode
    always_ff @(posedge clk) begin
        rd_pix <= off_pix;
        rd_bin <= off_bin;
    end

    // read mux
    // lane data is registered in the lane, ready in the ack cycle
    always_comb begin
        wb_o.ack = ack_q;
        if (is_hist) begin
            wb_o.dat = 32'(rd_data[off_lane]);
        end else if (wb_i.adr == `WB_CTRL_ADDR) begin
            wb_o.dat = 32'(cfg);
        end else if (wb_i.adr == `WB_STAT_ADDR) begin
            wb_o.dat = 32'(swap_cnt_q);
        end else begin
            // unmapped
            wb_o.dat = '0;
        end
    end

endmodule

`default_nettype wire

/* design/hist_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module hist_subsys_top (
    input  wire                       clk,
    input  wire                       res,
    input  wire hist_pkg::tdc_event_s evt,
    input  wire                       frame_end,
    input  wire hist_pkg::wb_m2s_s    wb_i,
    output hist_pkg::wb_s2m_s         wb_o,
    output logic                      hist_ready
);
    import hist_pkg::*;

    localparam int LANE_W    = $clog2(`HIST_LANES);
    localparam int LANE_SPAN = `HIST_PIX_PER_LANE * `HIST_BINS;

    lane_req_s              lane_req [`HIST_LANES];
    logic                   lane_frame_end;
    hist_cfg_s              cfg;
    logic                   rd_en;
    logic                   rd_pix;
    logic [`HIST_BIN_W-1:0] rd_bin;
    logic [`HIST_CNT_W-1:0] rd_data [`HIST_LANES];
    logic [`HIST_LANES-1:0] lane_swap;
    logic [`WB_ADDR_W-1:0]  rd_off;
    logic [LANE_W-1:0]      rd_lane;
    logic [`HIST_LANES-1:0] lane_rd_en;

    // event decode and lane select
    tdc_event_router u_router (
        .clk            (clk),
        .res            (res),
        .evt            (evt),
        .frame_end      (frame_end),
        .cfg            (cfg),
        .lane_req       (lane_req),
        .lane_frame_end (lane_frame_end)
    );

    // lane of the word being read
    // adr is held by the master until ack, so it still holds in the rd_en cycle
    assign rd_off  = wb_i.adr - `WB_HIST_BASE;
    assign rd_lane = LANE_W'(rd_off / LANE_SPAN);

    // one histogram lane per pixel pair
    generate
        for (genvar g = 0; g < `HIST_LANES; g++) begin : g_lane
            // only the addressed lane reads and clears
            assign lane_rd_en[g] = rd_en && (rd_lane == LANE_W'(g));

            hist_lane u_lane (
                .clk       (clk),
                .res       (res),
                .req       (lane_req[g]),
                .frame_end (lane_frame_end),
                .rd_en     (lane_rd_en[g]),
                .rd_pix    (rd_pix),
                .rd_bin    (rd_bin),
                .rd_data   (rd_data[g]),
                .swap      (lane_swap[g])
            );
        end
    endgenerate

    // host control, status and bank drain
    hist_wb_readout u_readout (
        .clk     (clk),
        .res     (res),
        .wb_i    (wb_i),
        .wb_o    (wb_o),
        .cfg     (cfg),
        .swap    (lane_swap[0]),
        .rd_en   (rd_en),
        .rd_pix  (rd_pix),
        .rd_bin  (rd_bin),
        .rd_data (rd_data)
    );

    // every lane swaps on the same frame_end
    assign hist_ready = lane_swap[0];

endmodule

`default_nettype wire

/* dv/hist_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module hist_clk_gen (
    output logic clk,
    output logic res
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // active low for the first 8 cycles
    initial begin
        res = 1'b0;
        repeat (8) @(posedge clk);
        res <= 1'b1;
    end

endmodule

`default_nettype wire

/* dv/hist_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module hist_assertions (
    input wire                       clk,
    input wire                       res,
    input wire hist_pkg::tdc_event_s evt,
    input wire                       frame_end,
    input wire hist_pkg::wb_m2s_s    wb_i,
    input wire hist_pkg::wb_s2m_s    wb_o,
    input wire                       hist_ready,
    input wire hist_pkg::lane_req_s  lane_req [`HIST_LANES]
);
    import hist_pkg::*;

    localparam int FE_W = $clog2(`HIST_ACQ_NUM + 2);

    logic [`HIST_LANES-1:0] lane_hit;
    logic [FE_W-1:0]        fe_cnt_q;
    // read by the testbench at the end of the run
    int                     fail_cnt = 0;

    always_comb begin
        for (int i = 0; i < `HIST_LANES; i++) begin
            lane_hit[i] = lane_req[i].hit;
        end
    end

    // frame_end pulses since the last hist_ready
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            fe_cnt_q <= '0;
        end else if (hist_ready) begin
            fe_cnt_q <= FE_W'(frame_end);
        end else if (frame_end) begin
            fe_cnt_q <= fe_cnt_q + 1'b1;
        end
    end

    // ack is a one-cycle strobe
    ack_one_cycle: assert property (@(posedge clk) disable iff (!res)
        wb_o.ack |=> !wb_o.ack)
        else begin
            fail_cnt++;
            $error("wishbone ack high for more than one cycle");
        end

    // no ack outside a bus cycle
    ack_in_cycle: assert property (@(posedge clk) disable iff (!res)
        wb_o.ack |-> (wb_i.cyc && wb_i.stb))
        else begin
            fail_cnt++;
            $error("wishbone ack without cyc and stb");
        end

    // swap only after the full acquisition count
    ready_after_acq: assert property (@(posedge clk) disable iff (!res)
        hist_ready |-> (fe_cnt_q == FE_W'(`HIST_ACQ_NUM)))
        else begin
            fail_cnt++;
            $error("hist_ready not after %0d frame_end pulses", `HIST_ACQ_NUM);
        end

    // never more frames than one histogram takes
    acq_bound: assert property (@(posedge clk) disable iff (!res)
        fe_cnt_q <= FE_W'(`HIST_ACQ_NUM))
        else begin
            fail_cnt++;
            $error("frame_end count passed the swap point without hist_ready");
        end

    // router latency is one register
    hit_from_valid: assert property (@(posedge clk) disable iff (!res)
        (|lane_hit) |-> $past(evt.valid))
        else begin
            fail_cnt++;
            $error("lane hit without a valid event one cycle earlier");
        end

endmodule

bind hist_subsys_top hist_assertions u_assertions (
    .clk        (clk),
    .res        (res),
    .evt        (evt),
    .frame_end  (frame_end),
    .wb_i       (wb_i),
    .wb_o       (wb_o),
    .hist_ready (hist_ready),
    .lane_req   (lane_req)
);

`default_nettype wire

/* dv/hist_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "hist_defs.svh"

module hist_tb;
    import hist_pkg::*;

    localparam int NUM_ROWS  = 4;
    localparam int NUM_EVT   = 15;
    localparam int NUM_CELLS = `HIST_LANES * `HIST_PIX_PER_LANE * `HIST_BINS;
    // about 1000 cycles per row, one more row for the last drain
    localparam int WATCHDOG_NS = (NUM_ROWS + 1) * 1000 * 10;
    localparam logic [4:0] DROP = 5'h10;

    // one acquisition set per row
    typedef struct packed {
        logic       mode;
        logic [7:0] window;
        logic [7:0] gap;
        logic [7:0] n_rand;
    } row_cfg_s;

    // exp_bin is the hand-decoded bin, DROP when the event is filtered
    typedef struct packed {
        logic [1:0]  row;
        logic [1:0]  acq;
        logic [2:0]  pixel;
        logic [11:0] word;
        logic [7:0]  rep;
        logic [4:0]  exp_bin;
    } evt_row_s;

    row_cfg_s row_tab [NUM_ROWS] = '{
        '{1'b0, 8'h00, 8'd4, 8'd30},
        '{1'b1, 8'h5a, 8'd6, 8'd30},
        '{1'b1, 8'hc3, 8'd4, 8'd0},
        '{1'b0, 8'h00, 8'd6, 8'd60}
    };

    evt_row_s evt_tab [NUM_EVT] = '{
        '{2'd0, 2'd0, 3'd0, 12'h3a7, 8'd5,  5'd3},
        '{2'd0, 2'd0, 3'd5, 12'hf01, 8'd2,  5'd15},
        '{2'd0, 2'd1, 3'd7, 12'h000, 8'd1,  5'd0},
        '{2'd0, 2'd2, 3'd2, 12'h812, 8'd3,  5'd8},
        '{2'd1, 2'd0, 3'd1, 12'h5a6, 8'd4,  5'd6},
        '{2'd1, 2'd0, 3'd3, 12'h5b6, 8'd3,  DROP},
        '{2'd1, 2'd1, 3'd6, 12'h5af, 8'd2,  5'd15},
        '{2'd1, 2'd2, 3'd4, 12'ha56, 8'd2,  DROP},
        '{2'd2, 2'd0, 3'd0, 12'hc30, 8'd1,  5'd0},
        '{2'd2, 2'd1, 3'd7, 12'hc3c, 8'd6,  5'd12},
        '{2'd2, 2'd2, 3'd2, 12'h3c3, 8'd2,  DROP},
        '{2'd3, 2'd0, 3'd4, 12'h7ff, 8'd40, 5'd7},
        '{2'd3, 2'd0, 3'd5, 12'h7a0, 8'd3,  5'd7},
        '{2'd3, 2'd0, 3'd4, 12'h7ff, 8'd5,  5'd7},
        '{2'd3, 2'd1, 3'd3, 12'hb3c, 8'd17, 5'd11}
    };

    logic       clk;
    logic       res;
    tdc_event_s evt;
    logic       frame_end;
    wb_m2s_s    wb_i;
    wb_s2m_s    wb_o;
    logic       hist_ready;

    // model of the active bank and of the bank being drained
    logic [15:0] exp_cnt [NUM_CELLS];
    logic [15:0] old_cnt [NUM_CELLS];
    int          seed;
    int          ready_cnt = 0;

    hist_clk_gen u_clk_gen (
        .clk (clk),
        .res (res)
    );

    hist_subsys_top u_dut (
        .clk        (clk),
        .res        (res),
        .evt        (evt),
        .frame_end  (frame_end),
        .wb_i       (wb_i),
        .wb_o       (wb_o),
        .hist_ready (hist_ready)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            stop_run($sformatf("CHECK FAILED at time %0t: %s, got %0h expected %0h",
                               $time, msg, got, exp));
        end
    endtask

    // decode rules, -1 for a dropped event
    function automatic int ref_bin(input logic mode, input logic [7:0] window,
                                   input logic [11:0] word);
        if (mode == 1'b0) begin
            return int'(word[11:8]);
        end
        if (word[11:4] == window) begin
            return int'(word[3:0]);
        end
        return -1;
    endfunction

    // one classic cycle, master holds everything until ack
    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        @(posedge clk);
        wb_i <= {1'b1, 1'b1, we, adr, wdat};
        do @(posedge clk); while (!wb_o.ack);
        rdat = wb_o.dat;
        wb_i <= '0;
    endtask

    task automatic send_event(input logic valid, input logic [2:0] pixel,
                              input logic [11:0] word);
        @(posedge clk);
        evt <= {valid, pixel, word};
    endtask

    task automatic count_hit(input logic [2:0] pixel, input logic [3:0] bin);
        exp_cnt[pixel * `HIST_BINS + bin] = exp_cnt[pixel * `HIST_BINS + bin] + 16'd1;
    endtask

    // table runs back to back, then random traffic, then the frame gap
    task automatic apply_acq(input int r, input int a);
        int          i;
        int          k;
        int          bin;
        logic [2:0]  pixel;
        logic [11:0] word;
        logic        valid;
        for (i = 0; i < NUM_EVT; i++) begin
            if (evt_tab[i].row == r && evt_tab[i].acq == a) begin
                for (k = 0; k < evt_tab[i].rep; k++) begin
                    send_event(1'b1, evt_tab[i].pixel, evt_tab[i].word);
                    if (!evt_tab[i].exp_bin[4]) begin
                        count_hit(evt_tab[i].pixel, evt_tab[i].exp_bin[3:0]);
                    end
                end
            end
        end
        for (k = 0; k < row_tab[r].n_rand / `HIST_ACQ_NUM; k++) begin
            pixel = 3'($random(seed));
            word  = 12'($random(seed));
            valid = (($random(seed) & 7) != 0);
            // half of the fine mode traffic inside the window
            if (row_tab[r].mode && (($random(seed) & 1) != 0)) begin
                word[11:4] = row_tab[r].window;
            end
            send_event(valid, pixel, word);
            bin = ref_bin(row_tab[r].mode, row_tab[r].window, word);
            if (valid && bin >= 0) begin
                count_hit(pixel, 4'(bin));
            end
        end
        @(posedge clk);
        evt <= '0;
        repeat (row_tab[r].gap) @(posedge clk);
    endtask

    // read every idle bin, then re-read one counted bin
    task automatic drain_and_check(input int row);
        int          i;
        int          first_hit;
        logic [31:0] rdata;
        first_hit = -1;
        for (i = 0; i < NUM_CELLS; i++) begin
            wb_access(1'b0, 8'(`WB_HIST_BASE + i), 32'd0, rdata);
            check_eq(rdata, 32'(old_cnt[i]),
                     $sformatf("row %0d pixel %0d bin %0d", row, i / `HIST_BINS, i % `HIST_BINS));
            if (old_cnt[i] != 16'd0 && first_hit < 0) begin
                first_hit = i;
            end
        end
        if (first_hit >= 0) begin
            wb_access(1'b0, 8'(`WB_HIST_BASE + first_hit), 32'd0, rdata);
            check_eq(rdata, 32'd0, $sformatf("second read of bin %0d after clear", first_hit));
        end
    endtask

    task automatic wait_ready(input int n);
        int i;
        for (i = 0; i < 20 && ready_cnt < n; i++) begin
            @(posedge clk);
        end
        if (ready_cnt < n) begin
            stop_run($sformatf("hist_ready did not pulse after frame_end at time %0t", $time));
        end
        check_eq(32'(ready_cnt), 32'(n), "hist_ready pulse count");
    endtask

    // map holes, reset values, ignored writes
    task automatic check_map();
        logic [31:0] rdata;
        wb_access(1'b0, `WB_CTRL_ADDR, 32'd0, rdata);
        check_eq(rdata, 32'd0, "control after reset");
        wb_access(1'b0, `WB_STAT_ADDR, 32'd0, rdata);
        check_eq(rdata, 32'd0, "status after reset");
        wb_access(1'b1, 8'h05, 32'h1ff, rdata);
        wb_access(1'b0, 8'h05, 32'd0, rdata);
        check_eq(rdata, 32'd0, "unmapped 0x05");
        wb_access(1'b0, 8'h3f, 32'd0, rdata);
        check_eq(rdata, 32'd0, "unmapped 0x3f");
        wb_access(1'b0, 8'hc0, 32'd0, rdata);
        check_eq(rdata, 32'd0, "unmapped 0xc0");
        wb_access(1'b0, `WB_CTRL_ADDR, 32'd0, rdata);
        check_eq(rdata, 32'd0, "control after unmapped write");
    endtask

    // swap pulses seen by the host
    always @(posedge clk) begin
        if (res && hist_ready) begin
            ready_cnt <= ready_cnt + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_run($sformatf("watchdog expired after %0d ns, run did not finish", WATCHDOG_NS));
    end

    initial begin
        logic [31:0] cfg_word;
        logic [31:0] rdata;
        seed      = 32'h4b85_ee37;
        evt       = '0;
        frame_end = 1'b0;
        wb_i      = '0;
        for (int i = 0; i < NUM_CELLS; i++) begin
            exp_cnt[i] = '0;
            old_cnt[i] = '0;
        end
        @(posedge res);
        @(posedge clk);
        check_map();
        for (int r = 0; r < NUM_ROWS; r++) begin
            cfg_word = {23'd0, row_tab[r].mode, row_tab[r].window};
            wb_access(1'b1, `WB_CTRL_ADDR, cfg_word, rdata);
            wb_access(1'b0, `WB_CTRL_ADDR, 32'd0, rdata);
            check_eq(rdata, cfg_word, $sformatf("control readback row %0d", r));
            for (int a = 0; a < `HIST_ACQ_NUM; a++) begin
                apply_acq(r, a);
                // previous histogram drained while new counts sit in the active bank
                if (a == 0 && r > 0) begin
                    drain_and_check(r - 1);
                end
                check_eq(32'(ready_cnt), 32'(r), $sformatf("early swap row %0d acq %0d", r, a));
                @(posedge clk);
                frame_end <= 1'b1;
                @(posedge clk);
                frame_end <= 1'b0;
            end
            wait_ready(r + 1);
            wb_access(1'b0, `WB_STAT_ADDR, 32'd0, rdata);
            check_eq(rdata, 32'(r + 1), $sformatf("status after row %0d", r));
            old_cnt = exp_cnt;
            for (int i = 0; i < NUM_CELLS; i++) begin
                exp_cnt[i] = '0;
            end
        end
        drain_and_check(NUM_ROWS - 1);
        if (u_dut.u_assertions.fail_cnt != 0) begin
            stop_run($sformatf("%0d assertion failures", u_dut.u_assertions.fail_cnt));
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* hist_subsys.f */
+incdir+include
design/hist_pkg.sv
design/tdc_event_router.sv
design/hist_lane.sv
design/hist_wb_readout.sv
design/hist_subsys_top.sv
dv/hist_clk_gen.sv
dv/hist_assertions.sv
dv/hist_tb.sv

/* Bender.yml */
package:
  name: hist_subsys

sources:
  - include_dirs:
      - include
    files:
      - design/hist_pkg.sv
      - design/tdc_event_router.sv
      - design/hist_lane.sv
      - design/hist_wb_readout.sv
      - design/hist_subsys_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/hist_clk_gen.sv
      - dv/hist_assertions.sv
      - dv/hist_tb.sv
